// ==== dl1_defs.svh ====
// Dimension macros shared by the L1 data cache blocks
`ifndef DL1_DEFS_SVH
`define DL1_DEFS_SVH

// Data word and address width
`define DL1_WORD_W      32

// Associativity
`define DL1_WAYS        2

// Sets per way
`define DL1_LINES       16

// Words per cache line
`define DL1_LINE_WORDS  4

// Refill beats from L2, two words per beat
`define DL1_FILL_BEATS  2

// Byte offset inside a word
`define DL1_BYTE_OFS    2

`endif

// ==== dl1_pkg.sv ====
// Shared types of the L1 data cache (address fields, lines, port bundles)
`include "dl1_defs.svh"

package dl1_pkg;

	typedef logic [`DL1_WORD_W-1:0] word_t;
	typedef logic [$clog2(`DL1_LINES)-1:0] index_t;
	typedef logic [$clog2(`DL1_LINE_WORDS)-1:0] word_sel_t;
	typedef logic [`DL1_WORD_W-`DL1_BYTE_OFS-$clog2(`DL1_LINE_WORDS)-$clog2(`DL1_LINES)-1:0] tag_t;

	// Word 0 sits in the low bits
	typedef word_t [`DL1_LINE_WORDS-1:0] line_t;

	typedef struct packed {
		tag_t   tag;
		index_t index;
	} line_addr_t;

	typedef logic [`DL1_WAYS-1:0] way_vec_t;

	typedef struct packed {
		logic  read;
		logic  write;
		word_t addr;
		word_t wdata;
	} cpu_req_t;

	// w1 is the lower word of the pair
	typedef struct packed {
		logic                               update;
		logic [$clog2(`DL1_FILL_BEATS)-1:0] beat;
		word_t                              w1;
		word_t                              w2;
	} fill_beat_t;

	typedef struct packed {
		line_addr_t line_addr;
		line_t      data;
	} evict_t;

endpackage

// ==== dl1_sram.sv ====
// Per-set storage array with a synchronous write and a combinational read
`include "dl1_defs.svh"

module dl1_sram
#(
	parameter type entry_t = logic
)
(
	input  logic            clk_l1,
	input  logic            wen,
	input  dl1_pkg::index_t waddr,
	input  entry_t          wdata,
	input  dl1_pkg::index_t raddr,
	output entry_t          rdata
);

	entry_t mem [`DL1_LINES];

	always_ff @(posedge clk_l1)
	begin
		if (wen)
			mem[waddr] <= wdata;
	end

	// Read straight from the array
	assign rdata = mem[raddr];

endmodule

// ==== dl1_state_bits.sv ====
// Valid and dirty flags for every set of one cache way
`include "dl1_defs.svh"

module dl1_state_bits
(
	input  logic            clk_l1,
	input  logic            rst_n,
	input  dl1_pkg::index_t index,
	input  logic            set_valid,
	input  logic            set_dirty,
	input  logic            clear,
	output logic            valid,
	output logic            dirty
);

	logic [`DL1_LINES-1:0] valid_q;
	logic [`DL1_LINES-1:0] dirty_q;

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (clear)
		begin
			// Eviction done
			valid_q[index] <= 1'b0;
			dirty_q[index] <= 1'b0;
		end
		else if (set_valid)
		begin
			// Fresh line from L2 is clean
			valid_q[index] <= 1'b1;
			dirty_q[index] <= 1'b0;
		end
		else if (set_dirty)
			dirty_q[index] <= 1'b1;
	end

	assign valid = valid_q[index];
	assign dirty = dirty_q[index];

endmodule

// ==== dl1_way.sv ====
// One cache way with tag and line arrays, state flags and hit compare
`include "dl1_defs.svh"

module dl1_way
(
	input  logic                clk_l1,
	input  logic                rst_n,
	input  dl1_pkg::index_t     index,
	input  dl1_pkg::tag_t       tag,
	input  dl1_pkg::word_sel_t  word_sel,
	input  dl1_pkg::word_t      cpu_wdata,
	input  logic                write_hit,
	input  dl1_pkg::fill_beat_t fill,
	input  logic                fill_sel,
	input  logic                evict_clear,
	output logic                hit,
	output logic                valid,
	output logic                dirty,
	output dl1_pkg::tag_t       rd_tag,
	output dl1_pkg::line_t      rd_line
);

	localparam int PAIR_WORDS = `DL1_LINE_WORDS / `DL1_FILL_BEATS;

	logic           fill_wen;
	logic           tag_wen;
	logic           line_wen;
	dl1_pkg::line_t line_new;

	//==========================================================================
	// Write side
	//==========================================================================

	assign fill_wen = fill_sel && fill.update;
	// Last beat installs the tag
	assign tag_wen  = fill_wen && (int'(fill.beat) == `DL1_FILL_BEATS - 1);
	assign line_wen = write_hit || fill_wen;

	// Merge the store word or the beat pair into the stored line
	always_comb
	begin
		line_new = rd_line;
		if (write_hit)
			line_new[word_sel] = cpu_wdata;
		if (fill_wen)
		begin
			line_new[PAIR_WORDS * int'(fill.beat)]     = fill.w1;
			line_new[PAIR_WORDS * int'(fill.beat) + 1] = fill.w2;
		end
	end

	dl1_sram #(.entry_t(dl1_pkg::tag_t)) i_tag_ram
	(
		.clk_l1 (clk_l1),
		.wen    (tag_wen),
		.waddr  (index),
		.wdata  (tag),
		.raddr  (index),
		.rdata  (rd_tag)
	);

	dl1_sram #(.entry_t(dl1_pkg::line_t)) i_line_ram
	(
		.clk_l1 (clk_l1),
		.wen    (line_wen),
		.waddr  (index),
		.wdata  (line_new),
		.raddr  (index),
		.rdata  (rd_line)
	);

	dl1_state_bits i_state
	(
		.clk_l1    (clk_l1),
		.rst_n     (rst_n),
		.index     (index),
		.set_valid (tag_wen),
		.set_dirty (write_hit),
		.clear     (evict_clear),
		.valid     (valid),
		.dirty     (dirty)
	);

	//==========================================================================
	// Hit compare
	//==========================================================================

	assign hit = valid && (rd_tag == tag);

	// Refill only targets a way that misses, so no set gets two copies of a line
	a_fill_no_dup: assert property (@(posedge clk_l1) disable iff (!rst_n)
		fill_wen |-> !hit)
		else $error("[ERROR] %0t refill into a way that already hits", $time);

endmodule

// ==== dl1_victim_select.sv ====
// Replacement way choice, lowest invalid way first, else a pseudo-random way
`include "dl1_defs.svh"

module dl1_victim_select
(
	input  logic              clk_l1,
	input  logic              rst_n,
	input  logic              step,
	input  dl1_pkg::way_vec_t valid,
	output dl1_pkg::way_vec_t victim
);

	logic [7:0] lfsr_q;

	// Galois LFSR, x^8+x^6+x^5+x^4+1
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
			lfsr_q <= 8'h01;
		else if (step)
			lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hb8 : 8'h00);
	end

	always_comb
	begin
		victim = '0;
		victim[lfsr_q[$clog2(`DL1_WAYS)-1:0]] = 1'b1;
		// Walk down so the lowest invalid way wins
		for (int i = `DL1_WAYS - 1; i >= 0; i--)
		begin
			if (!valid[i])
				victim = dl1_pkg::way_vec_t'(1) << i;
		end
	end

endmodule

// ==== dl1_miss_ctrl.sv ====
// Miss handling FSM for halt, dirty eviction, refill request and beat count
`include "dl1_defs.svh"

module dl1_miss_ctrl
(
	input  logic                clk_l1,
	input  logic                rst_n,
	input  logic                access,
	input  logic                hit_any,
	input  dl1_pkg::way_vec_t   victim,
	input  logic                victim_dirty,
	input  logic                dirty_ack,
	input  dl1_pkg::fill_beat_t fill,
	output logic                halt,
	output logic                step,
	output dl1_pkg::way_vec_t   fill_way,
	output dl1_pkg::way_vec_t   evict_clear,
	output logic                dirty_req,
	output logic                update_req
);

	typedef enum logic [1:0] {
		IDLE,
		EVICT,
		REQ,
		FILL
	} state_t;

	state_t                             state_q;
	state_t                             state_d;
	dl1_pkg::way_vec_t                  way_q;
	logic [$clog2(`DL1_FILL_BEATS)-1:0] beat_q;
	logic                               miss;
	logic                               filling;
	logic                               last_beat;

	assign miss      = access && !hit_any;
	assign filling   = (state_q == REQ) || (state_q == FILL);
	assign last_beat = int'(beat_q) == `DL1_FILL_BEATS - 1;

	//==========================================================================
	// State transitions
	//==========================================================================

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (miss)
					state_d = victim_dirty ? EVICT : REQ;
			EVICT:
				if (dirty_ack)
					state_d = REQ;
			// First beat closes the request
			REQ:
				if (fill.update)
					state_d = last_beat ? IDLE : FILL;
			FILL:
				if (fill.update && last_beat)
					state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= IDLE;
			way_q   <= '0;
			beat_q  <= '0;
		end
		else
		begin
			state_q <= state_d;
			// Victim is frozen for the whole miss
			if (step)
				way_q <= victim;
			if (filling && fill.update)
				beat_q <= last_beat ? '0 : beat_q + 1'b1;
		end
	end

	//==========================================================================
	// Outputs
	//==========================================================================

	assign halt        = miss || (state_q != IDLE);
	assign step        = (state_q == IDLE) && miss;
	assign fill_way    = (state_q == IDLE) ? '0 : way_q;
	assign evict_clear = ((state_q == EVICT) && dirty_ack) ? way_q : '0;
	assign dirty_req   = state_q == EVICT;
	assign update_req  = state_q == REQ;

	a_dirty_hold: assert property (@(posedge clk_l1) disable iff (!rst_n)
		dirty_req && !dirty_ack |=> dirty_req)
		else $error("[ERROR] %0t dirty_req dropped before dirty_ack", $time);

	a_req_excl: assert property (@(posedge clk_l1) disable iff (!rst_n)
		!(dirty_req && update_req))
		else $error("[ERROR] %0t dirty_req and update_req both high", $time);

	// L2 sends beats only after the refill request
	a_fill_expected: assert property (@(posedge clk_l1) disable iff (!rst_n)
		fill.update |-> filling)
		else $error("[ERROR] %0t fill beat without a pending refill", $time);

endmodule

// ==== dl1_cache.sv ====
// Two-way write-back L1 data cache top level
`include "dl1_defs.svh"

module dl1_cache
(
	input  logic                clk_l1,
	input  logic                rst_n,
	input  dl1_pkg::cpu_req_t   cpu,
	output dl1_pkg::word_t      data_read,
	output logic                halt,
	output logic                dirty_req,
	output dl1_pkg::evict_t     dirty_line,
	input  logic                dirty_ack,
	output logic                update_req,
	output dl1_pkg::line_addr_t update_addr,
	input  dl1_pkg::fill_beat_t fill
);

	localparam int SEL_W = $bits(dl1_pkg::word_sel_t);
	localparam int IDX_W = $bits(dl1_pkg::index_t);
	localparam int TAG_W = $bits(dl1_pkg::tag_t);

	dl1_pkg::tag_t      tag;
	dl1_pkg::index_t    index;
	dl1_pkg::word_sel_t word_sel;
	dl1_pkg::way_vec_t  way_hit;
	dl1_pkg::way_vec_t  way_valid;
	dl1_pkg::way_vec_t  way_dirty;
	dl1_pkg::way_vec_t  victim;
	dl1_pkg::way_vec_t  fill_way;
	dl1_pkg::way_vec_t  evict_clear;
	dl1_pkg::way_vec_t  sel_way;
	dl1_pkg::tag_t      rd_tag [`DL1_WAYS];
	dl1_pkg::line_t     rd_line [`DL1_WAYS];
	logic               step;

	// Address split
	assign word_sel = cpu.addr[`DL1_BYTE_OFS +: SEL_W];
	assign index    = cpu.addr[`DL1_BYTE_OFS + SEL_W +: IDX_W];
	assign tag      = cpu.addr[`DL1_WORD_W-1 -: TAG_W];

	for (genvar w = 0; w < `DL1_WAYS; w++)
	begin : g_way
		dl1_way i_way
		(
			.clk_l1      (clk_l1),
			.rst_n       (rst_n),
			.index       (index),
			.tag         (tag),
			.word_sel    (word_sel),
			.cpu_wdata   (cpu.wdata),
			.write_hit   (cpu.write && way_hit[w] && !halt),
			.fill        (fill),
			.fill_sel    (fill_way[w]),
			.evict_clear (evict_clear[w]),
			.hit         (way_hit[w]),
			.valid       (way_valid[w]),
			.dirty       (way_dirty[w]),
			.rd_tag      (rd_tag[w]),
			.rd_line     (rd_line[w])
		);
	end

	dl1_victim_select i_victim
	(
		.clk_l1 (clk_l1),
		.rst_n  (rst_n),
		.step   (step),
		.valid  (way_valid),
		.victim (victim)
	);

	// Latched way once a miss is running
	assign sel_way = (|fill_way) ? fill_way : victim;

	dl1_miss_ctrl i_ctrl
	(
		.clk_l1       (clk_l1),
		.rst_n        (rst_n),
		.access       (cpu.read || cpu.write),
		.hit_any      (|way_hit),
		.victim       (victim),
		.victim_dirty (|(sel_way & way_valid & way_dirty)),
		.dirty_ack    (dirty_ack),
		.fill         (fill),
		.halt         (halt),
		.step         (step),
		.fill_way     (fill_way),
		.evict_clear  (evict_clear),
		.dirty_req    (dirty_req),
		.update_req   (update_req)
	);

	//==========================================================================
	// Read word and victim line
	//==========================================================================

	always_comb
	begin
		data_read  = '0;
		dirty_line = '0;
		for (int i = 0; i < `DL1_WAYS; i++)
		begin
			if (way_hit[i])
				data_read = rd_line[i][word_sel];
			if (sel_way[i])
			begin
				dirty_line.line_addr.tag   = rd_tag[i];
				dirty_line.line_addr.index = index;
				dirty_line.data            = rd_line[i];
			end
		end
	end

	assign update_addr.tag   = tag;
	assign update_addr.index = index;

endmodule

// ==== tb_dl1_cache.sv ====
// Testbench for the two-way L1 data cache with an L2 model and a shadow memory
`include "dl1_defs.svh"

module tb_dl1_cache;

	localparam int ACCESSES   = 400;
	localparam int MISS_LIMIT = 60;
	localparam int KEYS       = 64;

	logic                clk_l1 = 1'b0;
	logic                rst_n;
	dl1_pkg::cpu_req_t   cpu;
	dl1_pkg::word_t      data_read;
	logic                halt;
	logic                dirty_req;
	dl1_pkg::evict_t     dirty_line;
	logic                dirty_ack;
	logic                update_req;
	dl1_pkg::line_addr_t update_addr;
	dl1_pkg::fill_beat_t fill;

	logic [31:0]    lfsr_state = 32'h7e2e3267;
	dl1_pkg::word_t shadow [KEYS];
	dl1_pkg::word_t l2_mem [KEYS];
	// One flag per line that a store sets and a refill clears
	logic [15:0]    written;
	logic           started;
	logic           repeat_access;

	dl1_cache i_dut
	(
		.clk_l1      (clk_l1),
		.rst_n       (rst_n),
		.cpu         (cpu),
		.data_read   (data_read),
		.halt        (halt),
		.dirty_req   (dirty_req),
		.dirty_line  (dirty_line),
		.dirty_ack   (dirty_ack),
		.update_req  (update_req),
		.update_addr (update_addr),
		.fill        (fill)
	);

	always #5 clk_l1 = ~clk_l1;

	//==========================================================================
	// Helpers
	//==========================================================================

	// Galois form of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	// Tag bits 9:8, set bits 5:4, word bits 3:2
	function automatic logic [5:0] word_key(input dl1_pkg::word_t addr);
		return {addr[9:8], addr[5:2]};
	endfunction

	function automatic logic [3:0] addr_line(input dl1_pkg::word_t addr);
		return {addr[9:8], addr[5:4]};
	endfunction

	function automatic dl1_pkg::word_t key_addr(input logic [5:0] k);
		return {22'd0, k[5:4], 2'b00, k[3:0], 2'b00};
	endfunction

	function automatic logic [3:0] line_key(input dl1_pkg::line_addr_t la);
		return {la.tag[1:0], la.index[1:0]};
	endfunction

	// Background L2 contents mixed over the whole address
	function automatic dl1_pkg::word_t pattern(input dl1_pkg::word_t addr);
		return addr * 32'h9e37_79b1 + 32'h7f4a_7c15;
	endfunction

	function automatic dl1_pkg::line_t shadow_line(input dl1_pkg::line_addr_t la);
		dl1_pkg::line_t l;
		for (int w = 0; w < `DL1_LINE_WORDS; w++)
			l[w] = shadow[{line_key(la), w[1:0]}];
		return l;
	endfunction

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_mismatch(input string what);
		$display("[ERROR] %0t %s", $time, what);
		abort_run();
	endtask

	// Shadow memory, line flags and L2 storage of evicted lines
	always @(posedge clk_l1)
	begin
		if (rst_n && cpu.write && !halt)
		begin
			shadow[word_key(cpu.addr)] <= cpu.wdata;
			written[addr_line(cpu.addr)] <= 1'b1;
		end
		if (rst_n && dirty_req && dirty_ack)
			for (int w = 0; w < `DL1_LINE_WORDS; w++)
				l2_mem[{line_key(dirty_line.line_addr), w[1:0]}] <= dirty_line.data[w];
		if (fill.update && fill.beat == 1'b1)
			written[addr_line(cpu.addr)] <= 1'b0;
	end

	//==========================================================================
	// Checks
	//==========================================================================

	a_idle_after_reset: assert property (@(posedge clk_l1) disable iff (!rst_n)
		!started |-> !dirty_req && !update_req && !halt)
		else report_mismatch("request or halt active before any access");

	a_read_data: assert property (@(posedge clk_l1) disable iff (!rst_n)
		cpu.read && !halt |-> data_read == shadow[word_key(cpu.addr)])
		else report_mismatch("read data differs from shadow memory");

	a_evict_data: assert property (@(posedge clk_l1) disable iff (!rst_n)
		dirty_req && dirty_ack |-> dirty_line.data == shadow_line(dirty_line.line_addr))
		else report_mismatch("evicted line differs from shadow memory");

	a_evict_written: assert property (@(posedge clk_l1) disable iff (!rst_n)
		dirty_req && dirty_ack |-> dirty_line.line_addr.tag < 3
			&& dirty_line.line_addr.index < 4 && written[line_key(dirty_line.line_addr)])
		else report_mismatch("eviction of a line not written since its fill");

	a_dirty_hold: assert property (@(posedge clk_l1) disable iff (!rst_n)
		dirty_req && !dirty_ack |=> dirty_req)
		else report_mismatch("dirty_req dropped before dirty_ack");

	a_update_hold: assert property (@(posedge clk_l1) disable iff (!rst_n)
		update_req && !fill.update |=> update_req)
		else report_mismatch("update_req dropped before the first fill beat");

	a_req_excl: assert property (@(posedge clk_l1) disable iff (!rst_n)
		!(dirty_req && update_req))
		else report_mismatch("dirty_req and update_req high together");

	// Line address drops the word and byte offsets
	a_update_addr: assert property (@(posedge clk_l1) disable iff (!rst_n)
		update_req |-> update_addr == cpu.addr[31:4])
		else report_mismatch("update_addr differs from the halted request");

	a_repeat_hit: assert property (@(posedge clk_l1) disable iff (!rst_n)
		repeat_access |-> !halt)
		else report_mismatch("repeated access did not hit");

	//==========================================================================
	// Stimulus and L2 model
	//==========================================================================

	initial
	begin
		dl1_pkg::word_t      addr;
		dl1_pkg::fill_beat_t fill_next;
		logic [1:0]          tag_sel;
		logic [5:0]          base;
		logic                ack_next;
		logic                have_last;
		int                  cycles;
		int                  ack_wait;
		int                  beats;

		rst_n = 1'b0;
		cpu = '0;
		dirty_ack = 1'b0;
		fill = '0;
		started = 1'b0;
		repeat_access = 1'b0;
		written = '0;
		have_last = 1'b0;
		addr = '0;
		for (int k = 0; k < KEYS; k++)
		begin
			shadow[k] = pattern(key_addr(6'(k)));
			l2_mem[k] = pattern(key_addr(6'(k)));
		end
		repeat (16) @(posedge clk_l1);
		#1 rst_n = 1'b1;
		repeat (4) @(posedge clk_l1);
		#1 started = 1'b1;

		for (int n = 0; n < ACCESSES; n++)
		begin
			repeat_access = have_last && (rand_bits(2) == 0);
			if (!repeat_access)
			begin
				// Three tags over four sets
				tag_sel = 2'(rand_bits(2));
				if (tag_sel == 2'd3)
					tag_sel = 2'd0;
				addr = key_addr({tag_sel, 4'(rand_bits(4))});
			end
			cpu.write = 1'(rand_bits(1));
			cpu.read  = !cpu.write;
			cpu.addr  = addr;
			cpu.wdata = rand_bits(32);
			cycles    = 0;
			ack_wait  = -1;
			beats     = 0;
			base      = word_key(addr) & 6'b111100;
			while (1)
			begin
				@(negedge clk_l1);
				if (!halt)
					break;
				ack_next = 1'b0;
				if (dirty_req && !dirty_ack)
				begin
					if (ack_wait < 0)
						ack_wait = int'(rand_bits(2));
					if (ack_wait == 0)
						ack_next = 1'b1;
					else
						ack_wait--;
				end
				else
					ack_wait = -1;
				fill_next = '0;
				if (beats < `DL1_FILL_BEATS && (update_req || beats > 0)
					&& rand_bits(1) == 0)
				begin
					fill_next.update = 1'b1;
					fill_next.beat   = 1'(beats);
					fill_next.w1     = l2_mem[base + 6'(2 * beats)];
					fill_next.w2     = l2_mem[base + 6'(2 * beats + 1)];
					beats++;
				end
				@(posedge clk_l1);
				#1;
				dirty_ack = ack_next;
				fill = fill_next;
				cycles++;
				if (cycles > MISS_LIMIT)
				begin
					$display("Timeout: halt stayed high too long for address %h", addr);
					abort_run();
				end
			end
			@(posedge clk_l1);
			#1;
			dirty_ack = 1'b0;
			fill = '0;
			have_last = 1'b1;
		end

		cpu = '0;
		repeat_access = 1'b0;
		repeat (4) @(posedge clk_l1);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+.
dl1_pkg.sv
dl1_sram.sv
dl1_state_bits.sv
dl1_way.sv
dl1_victim_select.sv
dl1_miss_ctrl.sv
dl1_cache.sv
tb_dl1_cache.sv
